// File: all.f
+incdir+hw
hw/mmm_pkg.sv
hw/adder_tree_log_n.sv
hw/multi_mode_multiplier.sv
hw/mmm_cfg_regs.sv
hw/mmm_req_queue.sv
hw/mmm_issue_ctrl.sv
hw/mmm_top.sv
tb/mmm_sva.sv
tb/tb_mmm.sv

// File: hw/adder_tree_log_n.sv
// Recursive column adder tree
`timescale 1ns/1ps

module adder_tree_log_n #(
  parameter int NUM_ELEMENTS = 3,
  parameter int BIT_LEN      = 32,
  parameter int N            = 3
) (
  input  logic [BIT_LEN-1:0] i_terms [NUM_ELEMENTS],
  output logic [BIT_LEN-1:0] o_s
);

  // Number of partial sums produced by this level
  localparam int NUM_GROUPS = (NUM_ELEMENTS + N - 1) / N;

  generate
    if (NUM_ELEMENTS <= N) begin : g_last
      // Few enough terms left to finish with one small adder
      always_comb begin
        o_s = '0;
        for (int k = 0; k < NUM_ELEMENTS; k++) begin
          o_s = o_s + i_terms[k];
        end
      end
    end else begin : g_level
      logic [BIT_LEN-1:0] sums [NUM_GROUPS];

      // Each group of N neighbouring terms collapses to one sum
      // The last group may be short when the count does not divide evenly
      always_comb begin
        for (int g = 0; g < NUM_GROUPS; g++) begin
          sums[g] = '0;
          for (int k = 0; k < N; k++) begin
            if (g*N + k < NUM_ELEMENTS) begin
              sums[g] = sums[g] + i_terms[g*N + k];
            end
          end
        end
      end

      // The next level sees only the group sums
      adder_tree_log_n #(
        .NUM_ELEMENTS (NUM_GROUPS),
        .BIT_LEN      (BIT_LEN),
        .N            (N)
      ) u_next (
        .i_terms (sums),
        .o_s     (o_s)
      );
    end
  endgenerate

endmodule

// File: hw/mmm_cfg_regs.sv
// Multiplier mode register
`timescale 1ns/1ps

module mmm_cfg_regs import mmm_pkg::*; (
  input  logic      i_clk,
  input  logic      i_rst,
  input  logic      i_cfg_we,
  input  mmm_mode_t i_cfg_mode,
  output mmm_ctl_t  o_ctl
);

  mmm_mode_t mode_q;

  // A write becomes visible to the datapath on the next cycle
  always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
      mode_q <= MODE_SQR;
    end else if (i_cfg_we) begin
      mode_q <= i_cfg_mode;
    end
  end

  // Exactly one flag is set for every register value
  // The unused encoding falls back to square
  always_comb begin
    o_ctl = '0;
    case (mode_q)
      MODE_MUL_LO: o_ctl.mul_lo = 1'b1;
      MODE_MUL_HI: o_ctl.mul_hi = 1'b1;
      default:     o_ctl.sqr    = 1'b1;
    endcase
  end

endmodule

// File: hw/mmm_consts.svh
// Multiply engine constants
`ifndef MMM_CONSTS_SVH
`define MMM_CONSTS_SVH

// Number of redundant words in one operand
`define MMM_NUM_WORDS 4
// Width of one redundant word, sized for a DSP input port
`define MMM_DSP_BITS 17
// Weight step between neighbouring words
`define MMM_WORD_BITS 16
// Terms summed per adder tree level
`define MMM_TREE_RADIX 3
// Request queue entries, also the sender's starting credit
`define MMM_QUEUE_DEPTH 4
// Credits the downstream consumer grants out of reset
`define MMM_RSP_CREDITS 2

`endif

// File: hw/mmm_issue_ctrl.sv
// Response credit and issue control
`timescale 1ns/1ps
`include "mmm_consts.svh"

module mmm_issue_ctrl (
  input  logic i_clk,
  input  logic i_rst,
  input  logic i_not_empty,
  input  logic i_rsp_credit,
  output logic o_pop,
  output logic o_rsp_valid
);

  localparam int CRED_W = $clog2(`MMM_RSP_CREDITS + 1);

  logic [CRED_W-1:0] credit_cnt;

  // Issue whenever work is queued and the consumer still has room
  assign o_pop = i_not_empty && (credit_cnt != '0);

  // Credit is spent at issue and returned by the consumer
  // Both may happen together and then cancel out
  always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
      credit_cnt <= CRED_W'(`MMM_RSP_CREDITS);
    end else begin
      case ({o_pop, i_rsp_credit})
        2'b10:   credit_cnt <= credit_cnt - 1'b1;
        2'b01:   credit_cnt <= credit_cnt + 1'b1;
        default: credit_cnt <= credit_cnt;
      endcase
    end
  end

  // The multiplier registers its result once, so valid trails the pop by one cycle
  always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
      o_rsp_valid <= 1'b0;
    end else begin
      o_rsp_valid <= o_pop;
    end
  end

endmodule

// File: hw/mmm_pkg.sv
// Multiply engine types
`include "mmm_consts.svh"

package mmm_pkg;

  // Mode as written through the configuration port
  typedef enum logic [1:0] {
    MODE_SQR    = 2'd0,
    MODE_MUL_LO = 2'd1,
    MODE_MUL_HI = 2'd2
  } mmm_mode_t;

  // One-hot control seen by the datapath, square sits in bit 0
  typedef struct packed {
    logic mul_hi;
    logic mul_lo;
    logic sqr;
  } mmm_ctl_t;

  // One multiply request in redundant word form
  typedef struct packed {
    logic [`MMM_NUM_WORDS-1:0][`MMM_DSP_BITS-1:0] a;
    logic [`MMM_NUM_WORDS-1:0][`MMM_DSP_BITS-1:0] b;
    logic [`MMM_NUM_WORDS-1:0][`MMM_DSP_BITS-1:0] add_term;
  } mmm_req_t;

  // Double length result after the single carry step
  typedef struct packed {
    logic [2*`MMM_NUM_WORDS-1:0][`MMM_DSP_BITS-1:0] dat;
  } mmm_rsp_t;

endpackage

// File: hw/mmm_req_queue.sv
// Credited request FIFO
`timescale 1ns/1ps
`include "mmm_consts.svh"

module mmm_req_queue import mmm_pkg::*; (
  input  logic     i_clk,
  input  logic     i_rst,
  input  logic     i_push,
  input  mmm_req_t i_push_data,
  input  logic     i_pop,
  output mmm_req_t o_head,
  output logic     o_not_empty
);

  localparam int DEPTH = `MMM_QUEUE_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);

  mmm_req_t         mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;
  logic             pop_en;

  // A pop on an empty queue has nothing to remove
  assign pop_en      = i_pop && o_not_empty;
  assign o_not_empty = (count != '0);
  assign o_head      = mem[rd_ptr];

  // Storage only, the pointers decide what is valid
  always_ff @(posedge i_clk) begin
    if (i_push) begin
      mem[wr_ptr] <= i_push_data;
    end
  end

  always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (i_push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop_en) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
      end
      // Simultaneous push and pop leave the occupancy unchanged
      case ({i_push, pop_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// File: hw/mmm_top.sv
// Multiply engine top level
`timescale 1ns/1ps

module mmm_top import mmm_pkg::*; (
  input  logic      i_clk,
  input  logic      i_rst,
  input  logic      i_req_valid,
  input  mmm_req_t  i_req,
  output logic      o_req_credit,
  input  logic      i_cfg_we,
  input  mmm_mode_t i_cfg_mode,
  output logic      o_rsp_valid,
  output mmm_rsp_t  o_rsp,
  input  logic      i_rsp_credit
);

  mmm_ctl_t ctl;
  mmm_req_t head;
  logic     not_empty;

  mmm_cfg_regs u_cfg_regs (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_cfg_we   (i_cfg_we),
    .i_cfg_mode (i_cfg_mode),
    .o_ctl      (ctl)
  );

  // Each pop frees a queue slot, so the pop strobe is the upstream credit
  mmm_req_queue u_req_queue (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_push      (i_req_valid),
    .i_push_data (i_req),
    .i_pop       (o_req_credit),
    .o_head      (head),
    .o_not_empty (not_empty)
  );

  mmm_issue_ctrl u_issue_ctrl (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_not_empty  (not_empty),
    .i_rsp_credit (i_rsp_credit),
    .o_pop        (o_req_credit),
    .o_rsp_valid  (o_rsp_valid)
  );

  // The head is consumed in the cycle it is popped
  multi_mode_multiplier u_mult (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_ctl      (ctl),
    .i_dat_a    (head.a),
    .i_dat_b    (head.b),
    .i_add_term (head.add_term),
    .o_dat      (o_rsp.dat)
  );

endmodule

// File: hw/multi_mode_multiplier.sv
// Three mode word grid multiplier
`timescale 1ns/1ps
`include "mmm_consts.svh"

module multi_mode_multiplier import mmm_pkg::*; (
  input  logic                                         i_clk,
  input  logic                                         i_rst,
  input  mmm_ctl_t                                     i_ctl,
  input  logic [`MMM_NUM_WORDS-1:0][`MMM_DSP_BITS-1:0]   i_dat_a,
  input  logic [`MMM_NUM_WORDS-1:0][`MMM_DSP_BITS-1:0]   i_dat_b,
  input  logic [`MMM_NUM_WORDS-1:0][`MMM_DSP_BITS-1:0]   i_add_term,
  output logic [2*`MMM_NUM_WORDS-1:0][`MMM_DSP_BITS-1:0] o_dat
);

  localparam int NW        = `MMM_NUM_WORDS;
  localparam int DSP       = `MMM_DSP_BITS;
  localparam int WORD      = `MMM_WORD_BITS;
  localparam int PROD_BITS = 2*DSP;
  // Room for the widest product half plus growth over a full column
  localparam int OUT_BITS  = (2*DSP - WORD) + $clog2(2*NW + 1);

  logic [PROD_BITS-1:0]             prod     [NW][NW];
  logic [OUT_BITS-1:0]              grid     [2*NW][2*NW];
  logic [OUT_BITS-1:0]              add_col  [2*NW];
  logic [OUT_BITS-1:0]              col_sum  [2*NW];
  logic [2*NW-1:0][DSP-1:0]         res_int;

  // One multiplier per cell with a small operand mux in front
  for (genvar gi = 0; gi < NW; gi++) begin : g_row
    for (genvar gj = 0; gj < NW; gj++) begin : g_cell
      logic [DSP-1:0] mul_a;
      logic [DSP-1:0] mul_b;

      always_comb begin
        mul_a = i_dat_a[gi];
        mul_b = i_dat_b[gj];
        if (i_ctl.mul_hi) begin
          // High half works on the words in reverse order
          mul_a = i_dat_a[NW-1-gi];
          mul_b = i_dat_b[NW-1-gj];
        end else if (i_ctl.sqr && gi > gj) begin
          // Lower triangle is idle in square mode, so it serves the mirrored rows
          mul_b = i_dat_b[NW-1-gj];
        end
      end

      assign prod[gi][gj] = mul_a * mul_b;
    end
  end

  // Add term words land in the first NW columns, last word first
  always_comb begin
    for (int c = 0; c < 2*NW; c++) begin
      add_col[c] = '0;
    end
    for (int i = 0; i < NW; i++) begin
      add_col[NW-1-i] = i_add_term[i];
    end
  end

  // Row i owns slot 2i for the lower-weight half and 2i+1 for the other half
  always_comb begin
    logic [PROD_BITS-1:0] p;
    p = '0;
    for (int c = 0; c < 2*NW; c++) begin
      for (int s = 0; s < 2*NW; s++) begin
        grid[c][s] = '0;
      end
    end
    for (int i = 0; i < NW; i++) begin
      for (int j = 0; j < NW; j++) begin
        unique case (1'b1)
          i_ctl.sqr: begin
            if (i <= j) begin
              // Past the midpoint the product comes from the mirrored cell
              p = (i + j < NW) ? prod[i][j] : prod[i][NW-1-j];
              if (i == j) begin
                grid[i+j][2*i]     = p[WORD-1:0];
                grid[i+j+1][2*i+1] = p[PROD_BITS-1:WORD];
              end else begin
                // Off-diagonal products appear twice, so shift left by one
                grid[i+j][2*i]     = {p[WORD-2:0], 1'b0};
                grid[i+j+1][2*i+1] = p[PROD_BITS-1:WORD-1];
              end
            end
          end
          i_ctl.mul_lo: begin
            grid[i+j][2*i]     = prod[i][j][WORD-1:0];
            grid[i+j+1][2*i+1] = prod[i][j][PROD_BITS-1:WORD];
          end
          i_ctl.mul_hi: begin
            // Reversed weights, the halves trade columns
            grid[i+j+1][2*i+1] = prod[i][j][WORD-1:0];
            grid[i+j][2*i]     = prod[i][j][PROD_BITS-1:WORD];
          end
        endcase
      end
    end
  end

  // Each column only ever fills a contiguous run of slots
  for (genvar gc = 0; gc < 2*NW; gc++) begin : g_col
    localparam int CNT  = (gc < NW) ? 2*gc + 1 : 4*NW - 1 - 2*gc;
    localparam int BASE = (gc < NW) ? 0 : 2*(gc - NW) + 1;
    logic [OUT_BITS-1:0] terms [CNT+1];

    always_comb begin
      for (int k = 0; k < CNT; k++) begin
        terms[k] = grid[gc][BASE+k];
      end
      terms[CNT] = add_col[gc];
    end

    adder_tree_log_n #(
      .NUM_ELEMENTS (CNT + 1),
      .BIT_LEN      (OUT_BITS),
      .N            (`MMM_TREE_RADIX)
    ) u_tree (
      .i_terms (terms),
      .o_s     (col_sum[gc])
    );
  end

  // Single carry step, upward normally and downward for the high half
  always_comb begin
    logic [OUT_BITS-WORD-1:0] carry;
    carry = '0;
    for (int c = 0; c < 2*NW; c++) begin
      carry = '0;
      if (i_ctl.mul_hi) begin
        if (c < 2*NW-1) carry = col_sum[c+1][OUT_BITS-1:WORD];
      end else if (c > 0) begin
        carry = col_sum[c-1][OUT_BITS-1:WORD];
      end
      res_int[c] = col_sum[c][WORD-1:0] + carry;
    end
  end

  always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
      o_dat <= '0;
    end else begin
      o_dat <= res_int;
    end
  end

endmodule

// File: tb/mmm_sva.sv
// Queue and issue assertions
`timescale 1ns/1ps
`include "mmm_consts.svh"

module mmm_sva #(
  parameter bit QUEUE_SIDE = 1'b0
) (
  input logic       i_clk,
  input logic       i_rst,
  input logic       i_push,
  input logic       i_full,
  input logic       i_pop,
  input logic       i_rsp_valid,
  input logic [3:0] i_credit_cnt
);

  if (QUEUE_SIDE) begin : g_queue
    // The sender only pushes while it still holds a queue credit
    a_no_overflow: assert property (@(posedge i_clk) disable iff (i_rst) !(i_push && i_full))
      else $error("push into a full request queue");
  end else begin : g_issue
    // Returned credits can never exceed what the consumer granted
    a_credit_max: assert property (@(posedge i_clk) disable iff (i_rst)
      i_credit_cnt <= `MMM_RSP_CREDITS)
      else $error("response credit count above its reset grant");
    // One register stage between issue and result
    a_valid_after_pop: assert property (@(posedge i_clk) disable iff (i_rst) i_pop |=> i_rsp_valid)
      else $error("pop not followed by a valid response");
    a_valid_needs_pop: assert property (@(posedge i_clk) disable iff (i_rst)
      i_rsp_valid |-> $past(i_pop))
      else $error("valid response without a pop one cycle earlier");
    // Nothing issues or completes in the cycle that follows a reset cycle
    a_reset_quiet: assert property (@(posedge i_clk) $past(i_rst) |-> !i_pop && !i_rsp_valid)
      else $error("pop or valid active right after reset");
  end

endmodule

bind mmm_req_queue mmm_sva #(.QUEUE_SIDE(1'b1)) u_sva (
  .i_clk        (i_clk),
  .i_rst        (i_rst),
  .i_push       (i_push),
  .i_full       (count == `MMM_QUEUE_DEPTH),
  .i_pop        (pop_en),
  .i_rsp_valid  (1'b0),
  .i_credit_cnt (4'd0)
);

bind mmm_issue_ctrl mmm_sva #(.QUEUE_SIDE(1'b0)) u_sva (
  .i_clk        (i_clk),
  .i_rst        (i_rst),
  .i_push       (1'b0),
  .i_full       (1'b0),
  .i_pop        (o_pop),
  .i_rsp_valid  (o_rsp_valid),
  .i_credit_cnt (4'(credit_cnt))
);

// File: tb/tb_mmm.sv
// Multiply engine testbench
`timescale 1ns/1ps
`include "mmm_consts.svh"

module tb_mmm import mmm_pkg::*; ();

  localparam int     NW             = `MMM_NUM_WORDS;
  localparam int     DSP            = `MMM_DSP_BITS;
  localparam int     CYCLE_NS       = 100;
  localparam int     NUM_REQ        = 30;
  localparam int     TIMEOUT_CYCLES = 20*NUM_REQ + 200;
  localparam longint WORD_MOD       = longint'(1) << `MMM_WORD_BITS;

  logic      i_clk;
  logic      i_rst;
  logic      i_req_valid;
  mmm_req_t  i_req;
  logic      o_req_credit;
  logic      i_cfg_we;
  mmm_mode_t i_cfg_mode;
  logic      o_rsp_valid;
  mmm_rsp_t  o_rsp;
  logic      i_rsp_credit;

  logic [31:0] lfsr_state = 32'had66;
  mmm_mode_t   mode_model = MODE_SQR;
  mmm_req_t    pending_q[$];
  mmm_rsp_t    expected_q[$];
  int          sent_count, rsp_count, credit_pulses, returned_credits;
  int          owed_credits, checks, mismatches, other_errors, cycle_count;
  bit          hold_credits = 1'b0;

  mmm_top i_mmm_top (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_req_valid  (i_req_valid),
    .i_req        (i_req),
    .o_req_credit (o_req_credit),
    .i_cfg_we     (i_cfg_we),
    .i_cfg_mode   (i_cfg_mode),
    .o_rsp_valid  (o_rsp_valid),
    .o_rsp        (o_rsp),
    .i_rsp_credit (i_rsp_credit)
  );

  initial begin
    i_clk = 1'b0;
    forever #(CYCLE_NS/2) i_clk = ~i_clk;
  end

  // Fibonacci LFSR with taps 32, 22, 2 and 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic random_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int k = 0; k < n; k++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
  endtask

  // Bit 16 is set on about one word in four to exercise the redundant form
  task automatic random_word(output logic [DSP-1:0] w);
    logic [31:0] lo;
    logic [31:0] flag;
    random_bits(16, lo);
    random_bits(2, flag);
    w = {flag[1:0] == 2'b11, lo[15:0]};
  endtask

  task automatic random_req(input bit same_ab, output mmm_req_t req);
    for (int k = 0; k < NW; k++) begin
      random_word(req.a[k]);
      random_word(req.b[k]);
      random_word(req.add_term[k]);
      if (same_ab) req.b[k] = req.a[k];
    end
  endtask

  // Column sums and one carry step, worked out from the placement rules
  function automatic mmm_rsp_t reference_result(input mmm_mode_t mode, input mmm_req_t req);
    longint   col [2*NW];
    longint   p;
    longint   carry;
    mmm_rsp_t rsp;
    for (int c = 0; c < 2*NW; c++) col[c] = 0;
    // Add term words fill the low columns last word first
    for (int i = 0; i < NW; i++) col[NW-1-i] += req.add_term[i];
    for (int i = 0; i < NW; i++) begin
      for (int j = 0; j < NW; j++) begin
        if (mode == MODE_MUL_HI) begin
          // Reversed operands, low half one column up and high half in place
          p = longint'(req.a[NW-1-i]) * longint'(req.b[NW-1-j]);
          col[i+j+1] += p % WORD_MOD;
          col[i+j]   += p / WORD_MOD;
        end else if (mode == MODE_MUL_LO || i <= j) begin
          p = longint'(req.a[i]) * longint'(req.b[j]);
          // Square counts each off-diagonal product twice
          if (mode != MODE_MUL_LO && i != j) p = 2 * p;
          col[i+j]   += p % WORD_MOD;
          col[i+j+1] += p / WORD_MOD;
        end
      end
    end
    for (int c = 0; c < 2*NW; c++) begin
      carry = 0;
      if (mode == MODE_MUL_HI) begin
        if (c < 2*NW-1) carry = col[c+1] / WORD_MOD;
      end else if (c > 0) begin
        carry = col[c-1] / WORD_MOD;
      end
      rsp.dat[c] = DSP'((col[c] % WORD_MOD) + carry);
    end
    return rsp;
  endfunction

  task automatic check_value(input string name, input logic [255:0] got,
                             input logic [255:0] exp);
    checks++;
    if (got !== exp) begin
      mismatches++;
      $display("[ERROR] t=%0t %s: got 0x%0h expected 0x%0h", $time, name, got, exp);
    end
  endtask

  // Waits for queue credit, then leaves valid high for the caller to drop
  task automatic send_req(input mmm_req_t req);
    @(posedge i_clk);
    while (sent_count - credit_pulses >= `MMM_QUEUE_DEPTH) begin
      i_req_valid <= 1'b0;
      @(posedge i_clk);
    end
    i_req_valid <= 1'b1;
    i_req       <= req;
    pending_q.push_back(req);
    sent_count++;
  endtask

  task automatic end_burst();
    @(posedge i_clk);
    i_req_valid <= 1'b0;
  endtask

  task automatic send_burst(input int n, input bit same_ab);
    mmm_req_t req;
    for (int k = 0; k < n; k++) begin
      random_req(same_ab, req);
      send_req(req);
    end
    end_burst();
  endtask

  task automatic write_mode(input mmm_mode_t m);
    @(posedge i_clk);
    i_cfg_we   <= 1'b1;
    i_cfg_mode <= m;
    @(posedge i_clk);
    i_cfg_we   <= 1'b0;
  endtask

  task automatic wait_drained();
    while (rsp_count != sent_count || returned_credits != rsp_count) @(posedge i_clk);
  endtask

  task automatic finish_run();
    $display("Checks: %0d, value mismatches: %0d, other failures: %0d",
             checks, mismatches, other_errors);
    if (mismatches == 0 && other_errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  endtask

  // Everything is sampled mid cycle where DUT outputs are settled
  always @(negedge i_clk) begin : monitor
    mmm_rsp_t exp_rsp;
    if (!i_rst) begin
      cycle_count++;
      if (i_rsp_credit) returned_credits++;
      // The head is issued under the mode held during this cycle
      if (o_req_credit) begin
        credit_pulses++;
        if (pending_q.size() == 0) begin
          other_errors++;
          $display("A request issued at %0t with none outstanding", $time);
        end else begin
          expected_q.push_back(reference_result(mode_model, pending_q.pop_front()));
        end
      end
      // A write seen now steers issues from the next cycle on
      if (i_cfg_we) mode_model = i_cfg_mode;
      if (o_rsp_valid) begin
        rsp_count++;
        owed_credits++;
        if (expected_q.size() == 0) begin
          other_errors++;
          $display("A response arrived at %0t with no result expected", $time);
        end else begin
          exp_rsp = expected_q.pop_front();
          for (int k = 0; k < 2*NW; k++) begin
            check_value($sformatf("o_rsp.dat[%0d]", k), o_rsp.dat[k], exp_rsp.dat[k]);
          end
        end
      end
    end
  end

  // The consumer hands back one credit per response unless it is holding them
  always @(posedge i_clk) begin
    if (!hold_credits && owed_credits > 0) begin
      i_rsp_credit <= 1'b1;
      owed_credits--;
    end else begin
      i_rsp_credit <= 1'b0;
    end
  end

  initial begin : watchdog
    while (cycle_count < TIMEOUT_CYCLES) @(posedge i_clk);
    other_errors++;
    $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    finish_run();
  end

  initial begin : main
    int rsp_before;
    int cred_before;
    i_rst        = 1'b1;
    i_req_valid  = 1'b0;
    i_req        = '0;
    i_cfg_we     = 1'b0;
    i_cfg_mode   = MODE_SQR;
    i_rsp_credit = 1'b0;
    repeat (5) @(posedge i_clk);
    i_rst <= 1'b0;
    // Outputs still hold their reset values until the next rising edge
    @(negedge i_clk);
    check_value("o_rsp", o_rsp, '0);
    check_value("o_rsp_valid", o_rsp_valid, 1'b0);
    check_value("o_req_credit", o_req_credit, 1'b0);

    // Full grid with a random add term
    write_mode(MODE_MUL_LO);
    send_burst(6, 1'b0);
    wait_drained();

    // Square with b equal to a
    write_mode(MODE_SQR);
    send_burst(6, 1'b1);
    wait_drained();

    // Reversed placement with the downward carry
    write_mode(MODE_MUL_HI);
    send_burst(6, 1'b0);
    wait_drained();

    // Mode switch while earlier requests still wait in the queue
    write_mode(MODE_MUL_LO);
    send_burst(3, 1'b0);
    write_mode(MODE_MUL_HI);
    send_burst(3, 1'b0);
    wait_drained();

    // Spend both response credits, then fill the queue while they are held
    hold_credits <= 1'b1;
    send_burst(2, 1'b0);
    while (rsp_count != sent_count) @(posedge i_clk);
    rsp_before  = rsp_count;
    cred_before = credit_pulses;
    send_burst(4, 1'b0);
    repeat (30) @(posedge i_clk);
    check_value("o_rsp_valid count under back-pressure", rsp_count, rsp_before);
    check_value("o_req_credit count under back-pressure", credit_pulses, cred_before);
    hold_credits <= 1'b0;
    wait_drained();
    check_value("o_req_credit total", credit_pulses, sent_count);
    finish_run();
  end

endmodule
